// File: sim/rv_golden.hex
// words 000-0ff program image, word 100 number of stores,
// then one store address and its data word per pair
@000
20000F93 FEC00093 00300113 123451B7 67818193  // x31 base, x1 -20, x2 3, x3 12345678
002082B3 005FA023 402082B3 005FA223 002192B3 005FA423 0020D2B3 005FA623  // add sub sll srl
4020D2B3 005FA823 0011F2B3 005FAA23 0021E2B3 005FAC23 0011C2B3 005FAE23  // sra and or xor
0020A2B3 025FA023 0020B2B3 025FA223  // slt sltu
06408293 025FA423 00419293 025FA623 0040D293 025FA823 4020D293 025FAA23  // addi slli srli srai
0F01F293 025FAC23 0030E293 025FAE23 FFF1C293 045FA023  // andi ori xori
FFF12293 045FA223 FFF13293 045FA423  // slti sltiu
ABCDE337 046FA623 00001317 046FA823  // lui auipc
043FAA23 054FA383 047FAC23  // sw lw sw
02100413 00210463 10040413 048FAE23  02200413 00208463 10040413 068FA023  // beq
02300413 00209463 10040413 068FA223  02400413 00211463 10040413 068FA423  // bne
02500413 0020C463 10040413 068FA623  02600413 00114463 10040413 068FA823  // blt
02700413 00115463 10040413 068FAA23  02800413 0020D463 10040413 068FAC23  // bge
02900413 00116463 10040413 068FAE23  02A00413 0020E463 10040413 088FA023  // bltu
02B00413 0020F463 10040413 088FA223  02C00413 00117463 10040413 088FA423  // bgeu
008004EF FFF00493 089FA623  // jal
00000517 00D505E7 FFF00593 08BFA823  // jalr to odd target
0000006F  // spin
@100
00000025
00000200 FFFFFFEF  00000204 FFFFFFE9  00000208 91A2B3C0  0000020C 1FFFFFFD
00000210 FFFFFFFD  00000214 12345668  00000218 1234567B  0000021C EDCBA994
00000220 00000001  00000224 00000000
00000228 00000050  0000022C 23456780  00000230 0FFFFFFE  00000234 FFFFFFFB
00000238 00000070  0000023C FFFFFFEF  00000240 EDCBA987  00000244 00000000
00000248 00000001
0000024C ABCDE000  00000250 000010B4  00000254 12345678  00000258 12345678
0000025C 00000021  00000260 00000122  00000264 00000023  00000268 00000124
0000026C 00000025  00000270 00000126  00000274 00000027  00000278 00000128
0000027C 00000029  00000280 0000012A  00000284 0000002B  00000288 0000012C
0000028C 0000018C  00000290 0000019C

// File: filelist.f
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_lsu.sv
hdl/rv_bus_arbiter.sv
hdl/rv_core.sv
sim/rv_core_chk.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decode.sv
  - hdl/rv_alu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_fetch.sv
  - hdl/rv_lsu.sv
  - hdl/rv_bus_arbiter.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_chk.sv
      - sim/tb_rv_core.sv

// File: sim/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

    localparam int          mem_words         = 256;
    localparam int          count_index       = 256;  // golden entry holding the store count
    localparam int          pairs_index       = 257;  // first address/data pair
    localparam int          golden_depth      = 512;
    localparam int          reset_cycles      = 16;
    localparam int          first_req_timeout = 40;
    localparam int          run_timeout       = 5000;
    localparam logic [31:0] lfsr_seed         = 32'h7db505ac;

    logic          clk;
    logic          rst;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    rv_pkg::addr_t wb_adr;
    rv_pkg::word_t wb_wdata;
    rv_pkg::word_t wb_rdata;
    logic          wb_ack;

    rv_pkg::word_t golden [golden_depth];
    rv_pkg::word_t mem [mem_words];
    logic [31:0]   lfsr;
    int            n_stores;
    int            store_idx;
    int            wait_left;
    logic          counting;    // wait count already drawn for this request
    logic          ack_next;
    rv_pkg::word_t rdata_next;

    rv_core #(.reset_vector(32'h0)) uut (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack)
    );

    bind rv_core rv_core_chk #(.reset_vector(reset_vector)) u_chk (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_ack(wb_ack)
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("Some tests failed");
        $display("%s", line);
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_addr(input string name, input rv_pkg::addr_t expected,
                              input rv_pkg::addr_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t expected,
                              input rv_pkg::word_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_wait_states(output int n);
        lfsr = lfsr_next(lfsr);
        n = lfsr[0];
        lfsr = lfsr_next(lfsr);
        n = n * 2 + lfsr[0];
    endtask

    task automatic load_golden();
        for (int i = 0; i < golden_depth; i++) begin
            golden[i] = {16'hbad0, i[15:0]};
        end
        $readmemh("sim/rv_golden.hex", golden);
        n_stores = golden[count_index];
        if (n_stores < 1 || pairs_index + 2 * n_stores > golden_depth) begin
            stop_with_error("golden file holds an invalid store count");
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = golden[i];
        end
    endtask

    task automatic record_store();
        mem[wb_adr[9:2]] = wb_wdata;
        if (store_idx >= n_stores) begin
            stop_with_error("the core stored more words than the golden file expects");
        end else begin
            check_addr($sformatf("store %0d address", store_idx),
                       golden[pairs_index + 2 * store_idx], wb_adr);
            check_word($sformatf("store %0d data", store_idx),
                       golden[pairs_index + 2 * store_idx + 1], wb_wdata);
            store_idx++;
        end
    endtask

    // memory slave that samples the bus at the edge and answers 1 ns later
    always @(posedge clk) begin
        ack_next   = 1'b0;
        rdata_next = wb_rdata;
        if (!rst) begin
            counting = 1'b0;
        end else if (wb_cyc && wb_stb && wb_ack) begin
            if (wb_we) begin
                record_store();
            end
            counting = 1'b0;  // transfer ended at this edge
        end else if (wb_cyc && wb_stb) begin
            if (wb_adr[1:0] != 2'b00) begin
                stop_with_error("bus address is not word aligned");
            end
            if (wb_adr >= 4 * mem_words) begin
                stop_with_error("bus address lies outside the memory");
            end
            if (!counting) begin
                draw_wait_states(wait_left);
                counting = 1'b1;
            end
            if (wait_left == 0) begin
                ack_next   = 1'b1;
                rdata_next = mem[wb_adr[9:2]];
            end else begin
                wait_left--;
            end
        end
        #1;
        wb_ack   = ack_next;
        wb_rdata = rdata_next;
    end

    task automatic wait_first_request();
        int cycles;
        cycles = 0;
        while (!wb_cyc && cycles < first_req_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_cyc) begin
            stop_with_error("timed out waiting for the first bus request after reset");
        end else if (wb_we) begin
            stop_with_error("first bus transfer after reset was a write");
        end else begin
            check_addr("first fetch address", 32'h0, wb_adr);
        end
    endtask

    initial begin
        int cycles;
        clk       = 1'b0;
        rst       = 1'b0;
        wb_ack    = 1'b0;
        wb_rdata  = '0;
        lfsr      = lfsr_seed;
        store_idx = 0;
        wait_left = 0;
        counting  = 1'b0;
        load_golden();

        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            #1;
            if ((wb_cyc | wb_stb | wb_we) !== 1'b0) begin
                stop_with_error("bus was active during reset");
            end
        end
        rst = 1'b1;

        wait_first_request();

        cycles = 0;
        while (store_idx < n_stores && uut.u_chk.fail_count == 0 &&
               cycles < run_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (uut.u_chk.fail_count != 0) begin
            stop_with_error("a bus protocol assertion failed");
        end else if (store_idx == n_stores) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_error($sformatf("timed out after %0d of %0d stores", store_idx, n_stores));
        end
    end

endmodule

// File: sim/rv_core_chk.sv
`timescale 1ns/1ns

module rv_core_chk #(
    parameter rv_pkg::addr_t reset_vector = '0
) (
    input logic          clk,
    input logic          rst,
    input logic          wb_cyc,
    input logic          wb_stb,
    input logic          wb_we,
    input rv_pkg::addr_t wb_adr,
    input rv_pkg::word_t wb_wdata,
    input logic          wb_ack
);
    logic first_seen;  // a request was seen since reset
    int   fail_count = 0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            first_seen <= 1'b0;
        end else if (wb_cyc) begin
            first_seen <= 1'b1;
        end
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_count++;
        end

    // wdata only matters on writes
    hold_while_waiting: assert property (@(posedge clk) disable iff (!rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr) && $stable(wb_we) &&
                                (!wb_we || $stable(wb_wdata)))
        else begin
            $error("bus request changed before ack");
            fail_count++;
        end

    idle_in_reset: assert property (@(posedge clk) !rst |-> !wb_cyc)
        else begin
            $error("wb_cyc high during reset");
            fail_count++;
        end

    first_is_fetch: assert property (@(posedge clk) disable iff (!rst)
        (wb_cyc && !first_seen) |-> (!wb_we && wb_adr == reset_vector))
        else begin
            $error("first request after reset is not a read of the reset vector");
            fail_count++;
        end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
    parameter rv_pkg::addr_t reset_vector = '0
) (
    input  logic          clk,
    input  logic          rst,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::addr_t wb_adr,
    output rv_pkg::word_t wb_wdata,
    input  rv_pkg::word_t wb_rdata,
    input  logic          wb_ack
);
    rv_pkg::core_state_t state;
    rv_pkg::core_state_t state_next;
    rv_pkg::addr_t       pc;
    rv_pkg::addr_t       pc_plus4;
    rv_pkg::addr_t       pc_exec_next;
    logic                fetch_start;
    logic                fetch_done;
    logic                mem_start;
    logic                mem_done;
    rv_pkg::word_t       instr;
    rv_pkg::reg_addr_t   rs1;
    rv_pkg::reg_addr_t   rs2;
    rv_pkg::reg_addr_t   rd;
    rv_pkg::word_t       imm;
    rv_pkg::alu_op_t     alu_op;
    rv_pkg::branch_t     branch;
    logic                use_imm;
    logic                reg_write;
    logic                is_load;
    logic                is_store;
    logic                is_jal;
    logic                is_jalr;
    logic                is_auipc;
    rv_pkg::word_t       rdata1;
    rv_pkg::word_t       rdata2;
    rv_pkg::word_t       alu_a;
    rv_pkg::word_t       alu_b;
    rv_pkg::word_t       alu_res;
    rv_pkg::word_t       load_data;
    rv_pkg::word_t       rf_wdata;
    logic                rf_we;
    logic                taken;
    logic                f_cyc;
    logic                f_stb;
    rv_pkg::addr_t       f_adr;
    logic                f_ack;
    logic                d_cyc;
    logic                d_stb;
    logic                d_we;
    rv_pkg::addr_t       d_adr;
    rv_pkg::word_t       d_wdata;
    logic                d_ack;
    rv_pkg::word_t       bus_rdata;

    always_comb begin
        state_next = state;
        case (state)
            rv_pkg::st_halt_reset: state_next = rv_pkg::st_fetch;
            rv_pkg::st_fetch:      if (fetch_done) state_next = rv_pkg::st_execute;
            rv_pkg::st_execute:    state_next = (is_load || is_store) ?
                                                rv_pkg::st_memory : rv_pkg::st_fetch;
            rv_pkg::st_memory:     if (mem_done) state_next = rv_pkg::st_fetch;
            default:               state_next = rv_pkg::st_halt_reset;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= rv_pkg::st_halt_reset;
            pc          <= reset_vector;
            fetch_start <= 1'b0;
        end else begin
            state       <= state_next;
            fetch_start <= (state != rv_pkg::st_fetch) && (state_next == rv_pkg::st_fetch);
            if (state == rv_pkg::st_execute && !(is_load || is_store)) begin
                pc <= pc_exec_next;
            end else if (state == rv_pkg::st_memory && mem_done) begin
                pc <= pc_plus4;
            end
        end
    end

    // slt/sltu leave the compare in bit 0
    always_comb begin
        case (branch)
            rv_pkg::br_eq:  taken = (alu_res == '0);
            rv_pkg::br_ne:  taken = (alu_res != '0);
            rv_pkg::br_lt,
            rv_pkg::br_ltu: taken = alu_res[0];
            rv_pkg::br_ge,
            rv_pkg::br_geu: taken = ~alu_res[0];
            default:        taken = 1'b0;
        endcase
    end

    assign pc_plus4     = pc + 32'd4;
    assign pc_exec_next = is_jalr ? {alu_res[31:1], 1'b0} :
                          (is_jal || taken) ? pc + imm : pc_plus4;
    assign alu_a        = is_auipc ? pc : rdata1;
    assign alu_b        = use_imm ? imm : rdata2;
    assign mem_start    = (state == rv_pkg::st_execute) && (is_load || is_store);
    assign rf_wdata     = (is_jal || is_jalr) ? pc_plus4 : is_load ? load_data : alu_res;
    assign rf_we        = reg_write && ((state == rv_pkg::st_execute && !is_load) ||
                                        (state == rv_pkg::st_memory && mem_done));

    rv_decode u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .branch(branch), .use_imm(use_imm), .reg_write(reg_write), .is_load(is_load),
        .is_store(is_store), .is_jal(is_jal), .is_jalr(is_jalr), .is_auipc(is_auipc)
    );

    rv_alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_res));

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rf_we),
        .wdata(rf_wdata), .rdata1(rdata1), .rdata2(rdata2)
    );

    rv_fetch u_fetch (
        .clk(clk), .rst(rst), .start(fetch_start), .pc(pc), .done(fetch_done),
        .instr(instr), .req_cyc(f_cyc), .req_stb(f_stb), .req_adr(f_adr),
        .ack(f_ack), .rdata(bus_rdata)
    );

    rv_lsu u_lsu (
        .clk(clk), .rst(rst), .start(mem_start), .we(is_store), .adr(alu_res),
        .wdata(rdata2), .done(mem_done), .load_data(load_data), .req_cyc(d_cyc),
        .req_stb(d_stb), .req_we(d_we), .req_adr(d_adr), .req_wdata(d_wdata),
        .ack(d_ack), .rdata(bus_rdata)
    );

    rv_bus_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .f_cyc(f_cyc), .f_stb(f_stb), .f_adr(f_adr), .f_ack(f_ack),
        .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we), .d_adr(d_adr), .d_wdata(d_wdata),
        .d_ack(d_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_wdata(wb_wdata), .wb_ack(wb_ack), .wb_rdata(wb_rdata), .rdata(bus_rdata)
    );

endmodule

// File: hdl/rv_bus_arbiter.sv
`timescale 1ns/1ns

module rv_bus_arbiter (
    input  logic          clk,
    input  logic          rst,
    input  logic          f_cyc,
    input  logic          f_stb,
    input  rv_pkg::addr_t f_adr,
    output logic          f_ack,
    input  logic          d_cyc,
    input  logic          d_stb,
    input  logic          d_we,
    input  rv_pkg::addr_t d_adr,
    input  rv_pkg::word_t d_wdata,
    output logic          d_ack,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::addr_t wb_adr,
    output rv_pkg::word_t wb_wdata,
    input  logic          wb_ack,
    input  rv_pkg::word_t wb_rdata,
    output rv_pkg::word_t rdata
);
    logic held;       // a transfer was granted last cycle
    logic held_data;  // and it went to the data side
    logic sel_data;

    // keep the owner while its cyc stays up, else data side wins
    always_comb begin
        if (held && (held_data ? d_cyc : f_cyc)) begin
            sel_data = held_data;
        end else begin
            sel_data = d_cyc;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held      <= 1'b0;
            held_data <= 1'b0;
        end else begin
            held      <= wb_cyc;
            held_data <= sel_data;
        end
    end

    assign wb_cyc   = sel_data ? d_cyc : f_cyc;  // low when nobody asks
    assign wb_stb   = sel_data ? d_stb : f_stb;
    assign wb_we    = sel_data & d_we;
    assign wb_adr   = sel_data ? d_adr : f_adr;
    assign wb_wdata = d_wdata;
    assign f_ack    = wb_ack & ~sel_data & f_cyc;
    assign d_ack    = wb_ack & sel_data & d_cyc;
    assign rdata    = wb_rdata;

endmodule

// File: hdl/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          we,
    input  rv_pkg::addr_t adr,
    input  rv_pkg::word_t wdata,
    output logic          done,
    output rv_pkg::word_t load_data,
    output logic          req_cyc,
    output logic          req_stb,
    output logic          req_we,
    output rv_pkg::addr_t req_adr,
    output rv_pkg::word_t req_wdata,
    input  logic          ack,
    input  rv_pkg::word_t rdata
);
    logic          busy;
    logic          we_q;
    rv_pkg::word_t data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q      <= we;
            req_adr   <= adr;
            req_wdata <= wdata;
        end
        if (busy && ack) begin
            data_q <= rdata;
        end
    end

    assign req_cyc   = busy;
    assign req_stb   = busy;
    assign req_we    = busy & we_q;
    assign done      = busy & ack;
    assign load_data = done ? rdata : data_q;  // bypass so the load writes back on ack

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/1ns

module rv_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  rv_pkg::addr_t pc,
    output logic          done,
    output rv_pkg::word_t instr,
    output logic          req_cyc,
    output logic          req_stb,
    output rv_pkg::addr_t req_adr,
    input  logic          ack,
    input  rv_pkg::word_t rdata
);
    logic busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (ack) begin
            busy <= 1'b0;  // drop cyc the cycle after ack
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_adr <= pc;  // held for the whole transfer
        end
        if (busy && ack) begin
            instr <= rdata;
        end
    end

    assign req_cyc = busy;
    assign req_stb = busy;
    assign done    = busy & ack;

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    rv_pkg::word_t regs [32];

    // x0 is never written, so it reads back zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: hdl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_pkg::alu_add: begin
                result = a + b;
            end
            rv_pkg::alu_sub: begin
                result = a - b;  // zero test for beq/bne
            end
            rv_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            rv_pkg::alu_and: begin
                result = a & b;
            end
            rv_pkg::alu_or: begin
                result = a | b;
            end
            rv_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_pkg::alu_slt: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
            end
            rv_pkg::alu_sltu: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            rv_pkg::alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output rv_pkg::branch_t   branch,
    output logic              use_imm,
    output logic              reg_write,
    output logic              is_load,
    output logic              is_store,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_auipc
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    rv_pkg::alu_op_t funct_op;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign rd        = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by register and immediate arithmetic
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (opcode == rv_pkg::op_reg && funct7_b5) ?
                                rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  funct_op = rv_pkg::alu_sll;
            3'b010:  funct_op = rv_pkg::alu_slt;
            3'b011:  funct_op = rv_pkg::alu_sltu;
            3'b100:  funct_op = rv_pkg::alu_xor;
            3'b101:  funct_op = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  funct_op = rv_pkg::alu_or;
            default: funct_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        imm       = '0;
        alu_op    = rv_pkg::alu_add;
        branch    = rv_pkg::br_none;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_auipc  = 1'b0;
        case (opcode)
            rv_pkg::op_reg: begin
                alu_op    = funct_op;
                reg_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                imm       = imm_i;
                alu_op    = funct_op;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_load: begin
                imm       = imm_i;
                use_imm   = 1'b1;
                reg_write = 1'b1;  // written when the data returns
                is_load   = 1'b1;
            end
            rv_pkg::op_store: begin
                imm      = imm_s;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            rv_pkg::op_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  begin branch = rv_pkg::br_eq;  alu_op = rv_pkg::alu_sub;  end
                    3'b001:  begin branch = rv_pkg::br_ne;  alu_op = rv_pkg::alu_sub;  end
                    3'b100:  begin branch = rv_pkg::br_lt;  alu_op = rv_pkg::alu_slt;  end
                    3'b101:  begin branch = rv_pkg::br_ge;  alu_op = rv_pkg::alu_slt;  end
                    3'b110:  begin branch = rv_pkg::br_ltu; alu_op = rv_pkg::alu_sltu; end
                    3'b111:  begin branch = rv_pkg::br_geu; alu_op = rv_pkg::alu_sltu; end
                    default: branch = rv_pkg::br_none;
                endcase
            end
            rv_pkg::op_lui: begin
                imm       = imm_u;
                alu_op    = rv_pkg::alu_pass_b;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_auipc  = 1'b1;
            end
            rv_pkg::op_jal: begin
                imm       = imm_j;
                reg_write = 1'b1;
                is_jal    = 1'b1;
            end
            rv_pkg::op_jalr: begin
                imm       = imm_i;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_jalr   = 1'b1;
            end
            default: branch = rv_pkg::br_none;  // unknown opcode runs as a no-op
        endcase
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;  // register values, bus data, immediates
    typedef logic [xlen-1:0] addr_t;  // byte address
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by the core
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_srl    = 4'd3,
        alu_sra    = 4'd4,
        alu_and    = 4'd5,
        alu_or     = 4'd6,
        alu_xor    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10  // lui
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch      = 2'd0,
        st_execute    = 2'd1,
        st_memory     = 2'd2,
        st_halt_reset = 2'd3  // one cycle after reset
    } core_state_t;

    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_lt   = 3'd3,
        br_ge   = 3'd4,
        br_ltu  = 3'd5,
        br_geu  = 3'd6
    } branch_t;

endpackage
